// ==== bip_cpu.f ====
design/bip_pkg.sv
design/program_memory.sv
design/data_memory.sv
design/cpu_control.sv
design/accumulator_datapath.sv
design/bip_cpu.sv
dv/bip_cpu_tb.sv

// ==== design/accumulator_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

// Accumulator, immediate extension and add/subtract unit
module accumulator_datapath (
  input  wire                i_clk,
  input  wire                i_rsta,
  input  bip_pkg::operand_t  i_operand,   // Immediate field
  input  bip_pkg::word_t     i_mem_data,  // Word read on the falling edge
  input  wire                i_wr_acc,    // Load accumulator
  input  wire  [1:0]         i_sel_a,     // Accumulator source
  input  wire                i_sel_b,     // ALU operand B source
  input  wire                i_sub,       // Subtract instead of add
  output bip_pkg::word_t     o_acc
);

  bip_pkg::word_t acc_q;
  bip_pkg::word_t imm_ext;
  bip_pkg::word_t alu_b;
  bip_pkg::word_t alu_res;
  bip_pkg::word_t acc_d;

  ////////////////////
  // Operand path
  ////////////////////
  // Sign extend 11 bit immediate to word
  assign imm_ext = {{(bip_pkg::DATA_W - bip_pkg::OPERAND_W){i_operand[bip_pkg::OPERAND_W-1]}},
                    i_operand};

  assign alu_b = (i_sel_b == bip_pkg::SEL_B_IMM) ? imm_ext : i_mem_data;

  // Wraps at 16 bits, no carry kept
  always_comb begin
    if (i_sub) begin
      alu_res = acc_q - alu_b;
    end else begin
      alu_res = acc_q + alu_b;
    end
  end

  // Accumulator source
  always_comb begin
    case (i_sel_a)
      bip_pkg::SEL_A_MEM: acc_d = i_mem_data;  // LD
      bip_pkg::SEL_A_IMM: acc_d = imm_ext;     // LDI
      default:            acc_d = alu_res;     // Arithmetic
    endcase
  end

  ////////////////////
  // Accumulator reg
  ////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      acc_q <= '0;
    end else if (i_wr_acc) begin
      acc_q <= acc_d;
    end
  end

  // Also the STO write data
  assign o_acc = acc_q;

endmodule

`default_nettype wire

// ==== design/bip_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

// Single-cycle accumulator CPU
// Program memory and data memory beside control and datapath
module bip_cpu (
  input  wire               i_clk,
  input  wire               i_rsta,
  input  wire               i_prog_we,    // Program load strobe, only in reset
  input  bip_pkg::pc_t      i_prog_addr,
  input  bip_pkg::word_t    i_prog_data,
  output bip_pkg::pc_t      o_pc,         // Observation
  output bip_pkg::word_t    o_acc,
  output logic              o_halt
);

  bip_pkg::pc_t       pc;
  bip_pkg::word_t     instr;
  bip_pkg::operand_t  operand;
  bip_pkg::word_t     acc;
  bip_pkg::word_t     ram_rd;         // Data memory read word
  logic               halt;
  logic               wr_ram;
  logic               wr_acc;
  logic [1:0]         sel_a;
  logic               sel_b;
  logic               sub;

  ////////////////////
  // Fetch
  ////////////////////
  program_memory #(
    .DEPTH   (bip_pkg::PROG_DEPTH)
  ) u_program_memory (
    .i_clk   (i_clk),
    .i_we    (i_prog_we),
    .i_waddr (i_prog_addr),
    .i_wdata (i_prog_data),
    .i_raddr (pc),
    .o_instr (instr)
  );

  ////////////////////
  // Control
  ////////////////////
  cpu_control u_cpu_control (
    .i_clk     (i_clk),
    .i_rsta    (i_rsta),
    .i_instr   (instr),
    .o_pc      (pc),
    .o_halt    (halt),
    .o_operand (operand),
    .o_wr_ram  (wr_ram),
    .o_wr_acc  (wr_acc),
    .o_sel_a   (sel_a),
    .o_sel_b   (sel_b),
    .o_sub     (sub)
  );

  // Data store, falling edge access
  data_memory #(
    .DEPTH  (bip_pkg::DATA_DEPTH)
  ) u_data_memory (
    .i_clk  (i_clk),
    .i_addr (operand),
    .i_data (acc),
    .i_wea  (wr_ram),
    .o_data (ram_rd)
  );

  ////////////////////
  // Datapath
  ////////////////////
  accumulator_datapath u_accumulator_datapath (
    .i_clk      (i_clk),
    .i_rsta     (i_rsta),
    .i_operand  (operand),
    .i_mem_data (ram_rd),
    .i_wr_acc   (wr_acc),
    .i_sel_a    (sel_a),
    .i_sel_b    (sel_b),
    .i_sub      (sub),
    .o_acc      (acc)
  );

  assign o_pc   = pc;
  assign o_acc  = acc;
  assign o_halt = halt;

endmodule

`default_nettype wire

// ==== design/bip_pkg.sv ====
`default_nettype none

package bip_pkg;

  ////////////////////
  // Widths and depths
  ////////////////////
  localparam int DATA_W     = 16;   // Accumulator and data word
  localparam int OPCODE_W   = 5;    // Upper instruction field
  localparam int OPERAND_W  = 11;   // Address or immediate
  localparam int PC_W       = 11;
  localparam int PROG_DEPTH = 2048; // Instruction words
  localparam int DATA_DEPTH = 2048; // Data words

  // Vector types
  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [OPCODE_W-1:0]  opcode_t;
  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [PC_W-1:0]      pc_t;

  ////////////////////
  // Opcodes
  ////////////////////
  localparam opcode_t OP_HLT  = 5'd0; // Stop fetching
  localparam opcode_t OP_STO  = 5'd1; // mem[op] = acc
  localparam opcode_t OP_LD   = 5'd2; // acc = mem[op]
  localparam opcode_t OP_LDI  = 5'd3; // acc = sext(op)
  localparam opcode_t OP_ADD  = 5'd4; // acc += mem[op]
  localparam opcode_t OP_ADDI = 5'd5; // acc += sext(op)
  localparam opcode_t OP_SUB  = 5'd6; // acc -= mem[op]
  localparam opcode_t OP_SUBI = 5'd7; // acc -= sext(op)

  // Accumulator load source
  localparam logic [1:0] SEL_A_MEM = 2'd0;
  localparam logic [1:0] SEL_A_IMM = 2'd1;
  localparam logic [1:0] SEL_A_ALU = 2'd2;

  // ALU second operand source
  localparam logic SEL_B_MEM = 1'b0;
  localparam logic SEL_B_IMM = 1'b1;

  // Control FSM
  typedef enum logic {
    ST_RUN  = 1'b0,
    ST_HALT = 1'b1
  } run_state_t;

endpackage

`default_nettype wire

// ==== design/cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

// Program counter, run/halt FSM and instruction decode
module cpu_control (
  input  wire                i_clk,
  input  wire                i_rsta,
  input  bip_pkg::word_t     i_instr,   // Current instruction
  output bip_pkg::pc_t       o_pc,      // Fetch address
  output logic               o_halt,    // Core stopped
  output bip_pkg::operand_t  o_operand, // Address or immediate
  output logic               o_wr_ram,  // Data memory write
  output logic               o_wr_acc,  // Accumulator load
  output logic [1:0]         o_sel_a,   // Accumulator source
  output logic               o_sel_b,   // ALU operand B source
  output logic               o_sub      // ALU subtract
);

  bip_pkg::run_state_t state_q;
  bip_pkg::pc_t        pc_q;
  bip_pkg::opcode_t    opcode;
  logic                run;             // Core may commit this cycle

  // Instruction fields
  assign opcode    = i_instr[bip_pkg::DATA_W-1 -: bip_pkg::OPCODE_W];
  assign o_operand = i_instr[bip_pkg::OPERAND_W-1:0];

  ////////////////////
  // PC and FSM
  ////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      state_q <= bip_pkg::ST_RUN;
      pc_q    <= '0;
    end else if (state_q == bip_pkg::ST_RUN) begin
      if (opcode == bip_pkg::OP_HLT) begin
        state_q <= bip_pkg::ST_HALT;    // PC stays on the HLT word
      end else begin
        pc_q <= pc_q + bip_pkg::pc_t'(1);
      end
    end
    // ST_HALT holds everything until reset
  end

  // Enables blocked in reset and after a halt
  assign run = (state_q == bip_pkg::ST_RUN) && !i_rsta;

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin
    o_wr_ram = 1'b0;
    o_wr_acc = 1'b0;
    o_sel_a  = bip_pkg::SEL_A_ALU;
    o_sel_b  = bip_pkg::SEL_B_MEM;
    o_sub    = 1'b0;
    case (opcode)
      bip_pkg::OP_STO: begin
        o_wr_ram = run;
      end
      bip_pkg::OP_LD: begin
        o_wr_acc = run;
        o_sel_a  = bip_pkg::SEL_A_MEM;
      end
      bip_pkg::OP_LDI: begin
        o_wr_acc = run;
        o_sel_a  = bip_pkg::SEL_A_IMM;
      end
      bip_pkg::OP_ADD: begin
        o_wr_acc = run;                 // acc + mem word
      end
      bip_pkg::OP_ADDI: begin
        o_wr_acc = run;
        o_sel_b  = bip_pkg::SEL_B_IMM;
      end
      bip_pkg::OP_SUB: begin
        o_wr_acc = run;
        o_sub    = 1'b1;
      end
      bip_pkg::OP_SUBI: begin
        o_wr_acc = run;
        o_sel_b  = bip_pkg::SEL_B_IMM;
        o_sub    = 1'b1;
      end
      default: begin
        // HLT and undefined opcodes commit nothing
      end
    endcase
  end

  assign o_pc   = pc_q;
  assign o_halt = (state_q == bip_pkg::ST_HALT);

endmodule

`default_nettype wire

// ==== design/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

// Single-port data RAM, no-change read mode
// Accessed on the falling edge so the word is ready before the next
// rising edge updates the accumulator
module data_memory #(
  parameter int DEPTH = bip_pkg::DATA_DEPTH
) (
  input  wire                i_clk,
  input  bip_pkg::operand_t  i_addr,  // Word address from operand field
  input  bip_pkg::word_t     i_data,  // Accumulator value for STO
  input  wire                i_wea,   // Write enable
  output bip_pkg::word_t     o_data   // Read word
);

  bip_pkg::word_t mem [DEPTH];
  bip_pkg::word_t rd_q = '0;          // Read register

  ////////////////////
  // Power-up contents
  ////////////////////
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = bip_pkg::word_t'(i);   // Each word holds its address
    end
  end

  ////////////////////
  // Falling edge port
  ////////////////////
  always_ff @(negedge i_clk) begin
    if (i_wea) begin
      mem[i_addr] <= i_data;          // Write cycle, read reg untouched
    end else begin
      rd_q <= mem[i_addr];            // Read by default
    end
  end

  // Valid until the next falling edge
  assign o_data = rd_q;

endmodule

`default_nettype wire

// ==== design/program_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

// Instruction store
// Written through the load port, read asynchronously by the fetch
module program_memory #(
  parameter int DEPTH = bip_pkg::PROG_DEPTH
) (
  input  wire             i_clk,
  input  wire             i_we,     // Load strobe
  input  bip_pkg::pc_t    i_waddr,  // Load address
  input  bip_pkg::word_t  i_wdata,  // Load word
  input  bip_pkg::pc_t    i_raddr,  // Fetch address from PC
  output bip_pkg::word_t  o_instr   // Fetched instruction
);

  bip_pkg::word_t mem [DEPTH];

  ////////////////////
  // Power-up contents
  ////////////////////
  // All zero, so unloaded words decode as HLT
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  ////////////////////
  // Load port
  ////////////////////
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata; // One edge write
    end
  end

  // Zero cycle fetch
  // needed for single-cycle execution
  assign o_instr = mem[i_raddr];

endmodule

`default_nettype wire

// ==== dv/bip_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Random program run on the CPU and checked against an instruction-level model
module bip_cpu_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int PROG_LEN     = 200;           // Random instructions before HLT
  localparam int LOAD_CYCLES  = PROG_LEN + 1;  // One word per edge including HLT
  localparam int RESET_CYCLES = 5;             // Reset held after the load
  localparam int HOLD_CYCLES  = 20;            // Observed after HLT
  localparam int MARGIN       = 50;
  localparam int ADDR_SPAN    = 32;            // Data words the program touches
  localparam int WATCHDOG_CYCLES = LOAD_CYCLES + RESET_CYCLES + LOAD_CYCLES + MARGIN;

  logic            clk;
  logic            rsta;
  logic            prog_we;
  bip_pkg::pc_t    prog_addr;
  bip_pkg::word_t  prog_data;
  bip_pkg::pc_t    pc;
  bip_pkg::word_t  acc;
  logic            halt;

  integer          seed = 17904;
  bip_pkg::word_t  program_words [LOAD_CYCLES];
  bip_pkg::word_t  model_mem [bip_pkg::DATA_DEPTH]; // Reference data store
  logic            stored [bip_pkg::DATA_DEPTH];    // Written by STO so far
  bip_pkg::word_t  model_acc;
  bip_pkg::pc_t    model_pc;
  logic            model_halt;
  int              reload_hits;                     // Reads of stored words

  bip_cpu dut (
    .i_clk       (clk),
    .i_rsta      (rsta),
    .i_prog_we   (prog_we),
    .i_prog_addr (prog_addr),
    .i_prog_data (prog_data),
    .o_pc        (pc),
    .o_acc       (acc),
    .o_halt      (halt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Checks
  ////////////////////
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic compare_pc(input bip_pkg::pc_t expected, input bip_pkg::pc_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch o_pc expected 0x%h actual 0x%h", expected, actual));
    end
  endtask

  task automatic compare_acc(input bip_pkg::word_t expected, input bip_pkg::word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch o_acc expected 0x%h actual 0x%h", expected, actual));
    end
  endtask

  task automatic compare_halt(input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch o_halt expected 0x%h actual 0x%h", expected, actual));
    end
  endtask

  // Sampled on the falling edge between accumulator updates
  task automatic check_outputs();
    compare_pc(model_pc, pc);
    compare_acc(model_acc, acc);
    compare_halt(model_halt, halt);
  endtask

  ////////////////////
  // Program and model
  ////////////////////
  task automatic build_program();
    int roll;
    int opc;
    int operand;
    for (int i = 0; i < PROG_LEN; i++) begin
      roll = $random(seed);
      if ((roll & 15) == 0) begin
        opc = 8 + ($unsigned($random(seed)) % 24); // Undefined opcode acts as no-op
      end else begin
        opc = 1 + ($unsigned($random(seed)) % 7);
      end
      case (opc)
        1, 2, 4, 6: operand = $unsigned($random(seed)) % ADDR_SPAN; // Dense collisions
        default:    operand = $random(seed) & 32'h7ff;              // Full immediate range
      endcase
      program_words[i] = {bip_pkg::opcode_t'(opc), bip_pkg::operand_t'(operand)};
    end
    program_words[PROG_LEN] = {bip_pkg::OP_HLT, bip_pkg::operand_t'(0)};
  endtask

  // One instruction as the ISA defines it
  task automatic step_model();
    bip_pkg::word_t    instr;
    bip_pkg::opcode_t  opc;
    bip_pkg::operand_t opnd;
    bip_pkg::word_t    imm;
    instr = program_words[model_pc];
    opc   = instr[15:11];
    opnd  = instr[10:0];
    imm   = bip_pkg::word_t'($signed(opnd)); // Immediate is signed
    if (opc == bip_pkg::OP_LD || opc == bip_pkg::OP_ADD || opc == bip_pkg::OP_SUB) begin
      if (stored[opnd]) begin
        reload_hits++;
      end
    end
    case (opc)
      bip_pkg::OP_HLT: model_halt = 1'b1;
      bip_pkg::OP_STO: begin
        model_mem[opnd] = model_acc;
        stored[opnd]    = 1'b1;
      end
      bip_pkg::OP_LD:   model_acc = model_mem[opnd];
      bip_pkg::OP_LDI:  model_acc = imm;
      bip_pkg::OP_ADD:  model_acc = model_acc + model_mem[opnd]; // Wraps at 16 bits
      bip_pkg::OP_ADDI: model_acc = model_acc + imm;
      bip_pkg::OP_SUB:  model_acc = model_acc - model_mem[opnd];
      bip_pkg::OP_SUBI: model_acc = model_acc - imm;
      default: ;                                                  // No-op
    endcase
    if (!model_halt) begin
      model_pc = model_pc + 1'b1;
    end
  endtask

  ////////////////////
  // Watchdog
  ////////////////////
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("Timeout, the CPU never halted within the cycle budget");
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    rsta        = 1'b1;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    model_acc   = '0;
    model_pc    = '0;
    model_halt  = 1'b0;
    reload_hits = 0;
    for (int i = 0; i < bip_pkg::DATA_DEPTH; i++) begin
      model_mem[i] = bip_pkg::word_t'(i); // Word holds its own address
      stored[i]    = 1'b0;
    end
    build_program();

    // Load under reset with outputs held at zero
    for (int i = 0; i < LOAD_CYCLES; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= bip_pkg::pc_t'(i);
      prog_data <= program_words[i];
      @(negedge clk);
      check_outputs();
    end
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      prog_we <= 1'b0;                    // Last word lands on the first edge
      @(negedge clk);
      check_outputs();
    end
    @(posedge clk);
    rsta <= 1'b0;

    // One instruction per rising edge
    while (!model_halt) begin
      step_model();
      @(posedge clk);
      @(negedge clk);
      check_outputs();
    end

    // Frozen after HLT
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_outputs();
    end

    // Stored words must have been read back at least once
    if (reload_hits == 0) begin
      fail_run("No LD, ADD or SUB ever read a word written by STO");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
